/* Makefile */
# Verilator build and run of the multi-FIFO testbench
TOP = mfifo_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx 'All tests passed!' $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+source
source/mfifo_pkg.sv
source/mfifo_ram.sv
source/mfifo_free_list.sv
source/mfifo_push_ctrl.sv
source/mfifo_ptr_mgr.sv
source/mfifo_pop_ctrl.sv
source/mfifo_top.sv
testbench/mfifo_checker.sv
testbench/mfifo_tb.sv

/* source/mfifo_defs.svh */
/*
 * Sizing macros for the shared-storage multi-FIFO.
 * Included by the package and by every module that sizes ports by FIFO count.
 */
`ifndef MFIFO_DEFS_SVH
`define MFIFO_DEFS_SVH

// Number of logical FIFOs sharing the storage
`define MFIFO_NUM_FIFOS 4
// Total entries in the shared data and pointer RAMs
`define MFIFO_DEPTH 16
// Payload width of one data word
`define MFIFO_WIDTH 8

// Widths derived from the sizes above
`define MFIFO_ADDR_W 4
`define MFIFO_ID_W 2
// Wide enough to hold a count of MFIFO_DEPTH itself
`define MFIFO_COUNT_W 5

`endif

/* source/mfifo_free_list.sv */
/*
 * Free-entry tracker for the shared storage.
 * Offers the lowest free address combinationally and takes freed entries
 * back one clock later.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_free_list (
  input  logic               clk,
  input  logic               rstN,
  input  logic               allocValid,
  input  logic               deallocValid,
  input  mfifo_pkg::addrT    deallocEntry,
  output mfifo_pkg::addrT    allocEntry,
  output logic               empty
);

  // One bit per entry, set while the entry holds no data
  logic [`MFIFO_DEPTH-1:0] freeMask;

  // Scan from the top down so the lowest set bit wins
  always_comb begin
    allocEntry = '0;
    for (int i = `MFIFO_DEPTH - 1; i >= 0; i--) begin
      if (freeMask[i]) begin
        allocEntry = mfifo_pkg::addrT'(i);
      end
    end
  end

  assign empty = ~|freeMask;

  // Allocation and deallocation never touch the same entry in one cycle,
  // since an allocated entry is free and a freed entry is in use
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      freeMask <= '1;
    end else begin
      if (allocValid) begin
        freeMask[allocEntry] <= 1'b0;
      end
      if (deallocValid) begin
        freeMask[deallocEntry] <= 1'b1;
      end
    end
  end

endmodule

/* source/mfifo_pkg.sv */
/*
 * Shared types for the multi-FIFO: entry addresses, FIFO IDs, data words,
 * counts and the pop-side staging slot states.
 */
`include "mfifo_defs.svh"

package mfifo_pkg;

  typedef logic [`MFIFO_ADDR_W-1:0] addrT;
  typedef logic [`MFIFO_ID_W-1:0] fifoIdT;
  typedef logic [`MFIFO_WIDTH-1:0] dataT;
  typedef logic [`MFIFO_COUNT_W-1:0] countT;

  // A slot is refilled by a data RAM read, so it waits one cycle in slotFill
  typedef enum logic [1:0] {
    slotEmpty,
    slotFill,
    slotFull
  } slotStateT;

endpackage

/* source/mfifo_pop_ctrl.sv */
/*
 * Pop side: one staging slot per FIFO, refilled through a round-robin grant.
 * A grant reads the head from the data RAM and frees the entry at once;
 * the word lands in the slot one cycle later and is offered by valid/ready.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_pop_ctrl (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            headValid,
  input  mfifo_pkg::addrT [`MFIFO_NUM_FIFOS-1:0] head,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            listEmpty,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            popReady,
  input  mfifo_pkg::dataT                        dataRdData,
  output logic [`MFIFO_NUM_FIFOS-1:0]            headReady,
  output logic                                   dataRdEn,
  output mfifo_pkg::addrT                        dataRdAddr,
  output logic [`MFIFO_NUM_FIFOS-1:0]            popValid,
  output mfifo_pkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData,
  output logic [`MFIFO_NUM_FIFOS-1:0]            popEmpty,
  output logic                                   deallocValid,
  output mfifo_pkg::addrT                        deallocEntry
);

  mfifo_pkg::slotStateT slotState [`MFIFO_NUM_FIFOS];
  // FIFO with the highest priority in the next arbitration
  mfifo_pkg::fifoIdT rrPtr;
  mfifo_pkg::fifoIdT grantId;
  logic grantValid;

  // First FIFO at or after rrPtr with a valid head and an empty slot
  always_comb begin
    int idx;
    grantValid = 1'b0;
    grantId    = '0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      idx = (int'(rrPtr) + i) % `MFIFO_NUM_FIFOS;
      if (!grantValid && headValid[idx] && slotState[idx] == mfifo_pkg::slotEmpty) begin
        grantValid = 1'b1;
        grantId    = mfifo_pkg::fifoIdT'(idx);
      end
    end
  end

  always_comb begin
    headReady = '0;
    if (grantValid) begin
      headReady[grantId] = 1'b1;
    end
  end

  // The read and the free share an edge, so the old word is captured first
  assign dataRdEn     = grantValid;
  assign dataRdAddr   = head[grantId];
  assign deallocValid = grantValid;
  assign deallocEntry = head[grantId];

  always_comb begin
    for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
      popValid[f] = slotState[f] == mfifo_pkg::slotFull;
      // A slot in slotFill still holds an item in flight
      popEmpty[f] = listEmpty[f] && slotState[f] == mfifo_pkg::slotEmpty;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rrPtr <= '0;
      for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
        slotState[f] <= mfifo_pkg::slotEmpty;
      end
    end else begin
      if (grantValid) begin
        rrPtr <= mfifo_pkg::fifoIdT'((int'(grantId) + 1) % `MFIFO_NUM_FIFOS);
      end
      for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
        case (slotState[f])
          mfifo_pkg::slotEmpty: if (headReady[f]) slotState[f] <= mfifo_pkg::slotFill;
          mfifo_pkg::slotFill:  slotState[f] <= mfifo_pkg::slotFull;
          mfifo_pkg::slotFull:  if (popReady[f]) slotState[f] <= mfifo_pkg::slotEmpty;
          default:              slotState[f] <= mfifo_pkg::slotEmpty;
        endcase
      end
    end
  end

  // Only one slot is ever in slotFill, so the shared read data has one owner
  always_ff @(posedge clk) begin
    for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
      if (slotState[f] == mfifo_pkg::slotFill) begin
        popData[f] <= dataRdData;
      end
    end
  end

endmodule

/* source/mfifo_ptr_mgr.sv */
/*
 * Linked-list manager: per-FIFO head, tail and item count.
 * New tails are linked behind the old tail in the pointer RAM, and an accepted
 * head fetches its successor, which arrives one cycle later.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_ptr_mgr (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   tailValid,
  input  mfifo_pkg::fifoIdT                      tailFifoId,
  input  mfifo_pkg::addrT                        tailEntry,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            headReady,
  input  mfifo_pkg::addrT                        ptrRdData,
  output logic [`MFIFO_NUM_FIFOS-1:0]            headValid,
  output mfifo_pkg::addrT [`MFIFO_NUM_FIFOS-1:0] head,
  output logic                                   ptrWrEn,
  output mfifo_pkg::addrT                        ptrWrAddr,
  output mfifo_pkg::addrT                        ptrWrData,
  output logic                                   ptrRdEn,
  output mfifo_pkg::addrT                        ptrRdAddr,
  output logic [`MFIFO_NUM_FIFOS-1:0]            listEmpty
);

  mfifo_pkg::addrT  tail [`MFIFO_NUM_FIFOS];
  mfifo_pkg::countT itemCount [`MFIFO_NUM_FIFOS];
  // High for the one cycle in which the next head is on its way from the RAM
  logic [`MFIFO_NUM_FIFOS-1:0] pending;
  logic [`MFIFO_NUM_FIFOS-1:0] tailHit;
  logic [`MFIFO_NUM_FIFOS-1:0] accept;

  always_comb begin
    ptrWrEn   = 1'b0;
    ptrWrAddr = '0;
    ptrWrData = tailEntry;
    ptrRdEn   = 1'b0;
    ptrRdAddr = '0;
    for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
      headValid[f] = (itemCount[f] != '0) && !pending[f];
      listEmpty[f] = itemCount[f] == '0;
      accept[f]    = headValid[f] && headReady[f];
      tailHit[f]   = tailValid && (tailFifoId == mfifo_pkg::fifoIdT'(f));
      // Only one tail arrives per cycle, so at most one link write
      if (tailHit[f] && itemCount[f] != '0) begin
        ptrWrEn   = 1'b1;
        ptrWrAddr = tail[f];
      end
      // headReady is one-hot, so at most one successor read
      if (accept[f] && itemCount[f] > mfifo_pkg::countT'(1)) begin
        ptrRdEn   = 1'b1;
        ptrRdAddr = head[f];
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pending <= '0;
      for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
        itemCount[f] <= '0;
      end
    end else begin
      for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
        pending[f] <= accept[f] && itemCount[f] > mfifo_pkg::countT'(1);
        case ({tailHit[f], accept[f]})
          2'b10:   itemCount[f] <= itemCount[f] + 1'b1;
          2'b01:   itemCount[f] <= itemCount[f] - 1'b1;
          default: itemCount[f] <= itemCount[f];
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
      if (tailHit[f]) begin
        tail[f] <= tailEntry;
      end
      // A tail that lands in a list about to go empty becomes the head directly,
      // because the last head was accepted without a successor read
      if (tailHit[f] && (itemCount[f] == '0 ||
          (accept[f] && itemCount[f] == mfifo_pkg::countT'(1)))) begin
        head[f] <= tailEntry;
      end else if (pending[f]) begin
        head[f] <= ptrRdData;
      end
    end
  end

endmodule

/* source/mfifo_push_ctrl.sv */
/*
 * Push side of the multi-FIFO: credit release toward the sender,
 * entry allocation, data RAM write and the new-tail announcement.
 * Credits leave one per cycle until the sender and storage hold all offered entries.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_push_ctrl (
  input  logic               clk,
  input  logic               rstN,
  input  logic               pushValid,
  input  mfifo_pkg::fifoIdT  pushFifoId,
  input  mfifo_pkg::dataT    pushData,
  input  logic               pushCreditStall,
  input  mfifo_pkg::countT   creditWithhold,
  input  logic               deallocValid,
  input  logic               freeEmpty,
  input  mfifo_pkg::addrT    allocEntry,
  output logic               pushCredit,
  output logic               pushFull,
  output logic               allocValid,
  output logic               dataWrEn,
  output mfifo_pkg::addrT    dataWrAddr,
  output mfifo_pkg::dataT    dataWrData,
  output logic               tailValid,
  output mfifo_pkg::fifoIdT  tailFifoId,
  output mfifo_pkg::addrT    tailEntry
);

  // Credits handed out and not yet returned through a deallocation.
  // A push moves a credit from the sender into an entry, so it leaves this unchanged
  mfifo_pkg::countT creditIssued;
  // One bit wider so withheld plus issued cannot wrap
  logic [`MFIFO_COUNT_W:0] creditUsed;
  logic creditOpen;
  logic creditGrant;

  assign creditUsed  = {1'b0, creditWithhold} + {1'b0, creditIssued};
  assign creditOpen  = creditUsed < (`MFIFO_COUNT_W + 1)'(`MFIFO_DEPTH);
  assign creditGrant = creditOpen && !pushCreditStall;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      creditIssued <= '0;
      pushCredit   <= 1'b0;
    end else begin
      pushCredit <= creditGrant;
      case ({creditGrant, deallocValid})
        2'b10:   creditIssued <= creditIssued + 1'b1;
        2'b01:   creditIssued <= creditIssued - 1'b1;
        default: creditIssued <= creditIssued;
      endcase
    end
  end

  // The sender only pushes on a credit, so the free list should never be empty here.
  // The guard keeps a misbehaving sender from corrupting the free list
  assign allocValid = pushValid && !freeEmpty;
  assign pushFull   = freeEmpty;

  // Data goes straight into the entry the free list offers this cycle
  assign dataWrEn   = allocValid;
  assign dataWrAddr = allocEntry;
  assign dataWrData = pushData;

  // The pointer manager sees the new entry one edge after the write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tailValid <= 1'b0;
    end else begin
      tailValid <= allocValid;
    end
  end

  always_ff @(posedge clk) begin
    if (allocValid) begin
      tailFifoId <= pushFifoId;
      tailEntry  <= allocEntry;
    end
  end

endmodule

/* source/mfifo_ram.sv */
/*
 * Single-port-pair RAM with one write and one registered read per cycle.
 * Read data appears one cycle after rdEn; it serves as data and pointer RAM.
 */
`timescale 1ns/1ps

module mfifo_ram #(
  parameter int Width = 8,
  parameter int Depth = 16
) (
  input  logic                     clk,
  input  logic                     wrEn,
  input  logic [$clog2(Depth)-1:0] wrAddr,
  input  logic [Width-1:0]         wrData,
  input  logic                     rdEn,
  input  logic [$clog2(Depth)-1:0] rdAddr,
  output logic [Width-1:0]         rdData
);

  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Read data holds its value between reads
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

/* source/mfifo_top.sv */
/*
 * Multi-FIFO top level: push and pop controllers, free list, pointer manager
 * and the data and pointer RAMs. Push is valid/credit, each FIFO pops by valid/ready.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_top (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   pushValid,
  input  mfifo_pkg::fifoIdT                      pushFifoId,
  input  mfifo_pkg::dataT                        pushData,
  input  logic                                   pushCreditStall,
  input  mfifo_pkg::countT                       creditWithhold,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            popReady,
  output logic                                   pushCredit,
  output logic                                   pushFull,
  output logic [`MFIFO_NUM_FIFOS-1:0]            popValid,
  output mfifo_pkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData,
  output logic [`MFIFO_NUM_FIFOS-1:0]            popEmpty
);

  // Allocation and deallocation
  logic allocValid;
  logic freeEmpty;
  mfifo_pkg::addrT allocEntry;
  logic deallocValid;
  mfifo_pkg::addrT deallocEntry;

  // New tails and list heads
  logic tailValid;
  mfifo_pkg::fifoIdT tailFifoId;
  mfifo_pkg::addrT tailEntry;
  logic [`MFIFO_NUM_FIFOS-1:0] headValid;
  logic [`MFIFO_NUM_FIFOS-1:0] headReady;
  logic [`MFIFO_NUM_FIFOS-1:0] listEmpty;
  mfifo_pkg::addrT [`MFIFO_NUM_FIFOS-1:0] head;

  // RAM ports
  logic dataWrEn;
  mfifo_pkg::addrT dataWrAddr;
  mfifo_pkg::dataT dataWrData;
  logic dataRdEn;
  mfifo_pkg::addrT dataRdAddr;
  mfifo_pkg::dataT dataRdData;
  logic ptrWrEn;
  mfifo_pkg::addrT ptrWrAddr;
  mfifo_pkg::addrT ptrWrData;
  logic ptrRdEn;
  mfifo_pkg::addrT ptrRdAddr;
  mfifo_pkg::addrT ptrRdData;

  mfifo_push_ctrl pushCtrl0 (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCreditStall,
    .creditWithhold, .deallocValid, .freeEmpty, .allocEntry, .pushCredit,
    .pushFull, .allocValid, .dataWrEn, .dataWrAddr, .dataWrData,
    .tailValid, .tailFifoId, .tailEntry
  );

  mfifo_free_list freeList0 (
    .clk, .rstN, .allocValid, .deallocValid, .deallocEntry, .allocEntry,
    .empty(freeEmpty)
  );

  mfifo_ptr_mgr ptrMgr0 (
    .clk, .rstN, .tailValid, .tailFifoId, .tailEntry, .headReady, .ptrRdData,
    .headValid, .head, .ptrWrEn, .ptrWrAddr, .ptrWrData, .ptrRdEn, .ptrRdAddr,
    .listEmpty
  );

  mfifo_pop_ctrl popCtrl0 (
    .clk, .rstN, .headValid, .head, .listEmpty, .popReady, .dataRdData,
    .headReady, .dataRdEn, .dataRdAddr, .popValid, .popData, .popEmpty,
    .deallocValid, .deallocEntry
  );

  mfifo_ram #(.Width(`MFIFO_WIDTH), .Depth(`MFIFO_DEPTH)) dataRam0 (
    .clk, .wrEn(dataWrEn), .wrAddr(dataWrAddr), .wrData(dataWrData),
    .rdEn(dataRdEn), .rdAddr(dataRdAddr), .rdData(dataRdData)
  );

  // Entry i of the pointer RAM holds the entry that follows i in its list
  mfifo_ram #(.Width(`MFIFO_ADDR_W), .Depth(`MFIFO_DEPTH)) ptrRam0 (
    .clk, .wrEn(ptrWrEn), .wrAddr(ptrWrAddr), .wrData(ptrWrData),
    .rdEn(ptrRdEn), .rdAddr(ptrRdAddr), .rdData(ptrRdData)
  );

endmodule

/* testbench/mfifo_checker.sv */
/*
 * Scoreboard for the multi-FIFO testbench.
 * Mirrors every push in a per-FIFO reference queue and checks each pop
 * handshake and each stalled pop against it; counts go back to the testbench.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_checker (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   pushValid,
  input  mfifo_pkg::fifoIdT                      pushFifoId,
  input  mfifo_pkg::dataT                        pushData,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            popReady,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            popValid,
  input  mfifo_pkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData,
  input  logic [`MFIFO_NUM_FIFOS-1:0]            popEmpty,
  output int                                     mismatches,
  output int                                     pops,
  output logic [`MFIFO_NUM_FIFOS-1:0]            queued
);

  // Words pushed and not yet popped, oldest first
  mfifo_pkg::dataT refQueue [`MFIFO_NUM_FIFOS][$];
  // Pops that were offered but not taken at the previous edge
  logic [`MFIFO_NUM_FIFOS-1:0] stalled;
  mfifo_pkg::dataT stalledData [`MFIFO_NUM_FIFOS];

  always @(posedge clk) begin
    mfifo_pkg::dataT expected;
    if (!rstN) begin
      mismatches = 0;
      pops = 0;
      queued = '0;
      stalled = '0;
    end else begin
      // A word needs several cycles to reach a slot, so queue it before any pop
      if (pushValid) begin
        refQueue[pushFifoId].push_back(pushData);
      end
      for (int f = 0; f < `MFIFO_NUM_FIFOS; f++) begin
        // A stalled word must stay on offer, unchanged
        if (stalled[f] && !popValid[f]) begin
          $display("Mismatch popValid[%0d]: expected 1, got 0 while stalled", f);
          mismatches++;
        end else if (stalled[f] && popData[f] !== stalledData[f]) begin
          $display("Mismatch popData[%0d]: expected %h, got %h while stalled",
                   f, stalledData[f], popData[f]);
          mismatches++;
        end
        // A full slot means the FIFO cannot be empty
        if (popValid[f] && popEmpty[f]) begin
          $display("Mismatch popEmpty[%0d]: expected 0, got 1 while popValid is high", f);
          mismatches++;
        end
        // Words of other FIFOs must never show up here
        if (popValid[f] && refQueue[f].size() == 0) begin
          $display("FIFO %0d offers data %h although nothing is queued for it",
                   f, popData[f]);
          mismatches++;
        end else if (popValid[f] && popReady[f]) begin
          expected = refQueue[f].pop_front();
          pops++;
          if (popData[f] !== expected) begin
            $display("Mismatch popData[%0d]: expected %h, got %h", f, expected, popData[f]);
            mismatches++;
          end
        end
        stalled[f] = popValid[f] && !popReady[f];
        stalledData[f] = popData[f];
        queued[f] = refQueue[f].size() != 0;
      end
    end
  end

endmodule

/* testbench/mfifo_tb.sv */
/*
 * Testbench for the shared-storage multi-FIFO.
 * A credit-counting sender applies a stimulus table and random traffic to dut0,
 * chk0 scores every pop, and one line per test plus a summary close the run.
 */
`timescale 1ns/1ps
`include "mfifo_defs.svh"

module mfifo_tb;

  localparam int WaitLimit = 500;
  localparam int NumRows = 24;

  // One push per row, sent while popReady holds the row's pattern
  typedef struct packed {
    logic [3:0]        testNum;
    mfifo_pkg::fifoIdT fifoId;
    mfifo_pkg::dataT   data;
    logic [3:0]        ready;
  } rowT;

  localparam rowT StimTable [NumRows] = '{
    // Ten words through FIFO 1
    '{4'd2, 2'd1, 8'h10, 4'hF}, '{4'd2, 2'd1, 8'h11, 4'hF}, '{4'd2, 2'd1, 8'h12, 4'hF},
    '{4'd2, 2'd1, 8'h13, 4'hF}, '{4'd2, 2'd1, 8'h14, 4'hF}, '{4'd2, 2'd1, 8'h15, 4'hF},
    '{4'd2, 2'd1, 8'h16, 4'hF}, '{4'd2, 2'd1, 8'h17, 4'hF}, '{4'd2, 2'd1, 8'h18, 4'hF},
    '{4'd2, 2'd1, 8'h19, 4'hF},
    // Spread over all four FIFOs
    '{4'd3, 2'd0, 8'h20, 4'hF}, '{4'd3, 2'd1, 8'h21, 4'hF}, '{4'd3, 2'd2, 8'h22, 4'hF},
    '{4'd3, 2'd3, 8'h23, 4'hF}, '{4'd3, 2'd3, 8'h24, 4'hF}, '{4'd3, 2'd2, 8'h25, 4'hF},
    '{4'd3, 2'd1, 8'h26, 4'hF}, '{4'd3, 2'd0, 8'h27, 4'hF},
    // FIFO 2 held back while the others flow
    '{4'd4, 2'd2, 8'h30, 4'hB}, '{4'd4, 2'd0, 8'h31, 4'hB}, '{4'd4, 2'd2, 8'h32, 4'hB},
    '{4'd4, 2'd1, 8'h33, 4'hB}, '{4'd4, 2'd2, 8'h34, 4'hB}, '{4'd4, 2'd3, 8'h35, 4'hB}
  };

  logic clk;
  logic rstN;
  logic pushValid;
  mfifo_pkg::fifoIdT pushFifoId;
  mfifo_pkg::dataT pushData;
  logic pushCreditStall;
  mfifo_pkg::countT creditWithhold;
  logic [`MFIFO_NUM_FIFOS-1:0] popReady;
  logic pushCredit;
  logic pushFull;
  logic [`MFIFO_NUM_FIFOS-1:0] popValid;
  mfifo_pkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData;
  logic [`MFIFO_NUM_FIFOS-1:0] popEmpty;
  int mismatches;
  int pops;
  logic [`MFIFO_NUM_FIFOS-1:0] queued;

  int seed = 46907;
  logic randomReady;
  int creditsIn;
  int pushesSent;
  int tbErrors;
  int errMark;
  int testsRun;
  int testsFailed;

  mfifo_top dut0 (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCreditStall,
    .creditWithhold, .popReady, .pushCredit, .pushFull, .popValid, .popData, .popEmpty
  );

  mfifo_checker chk0 (
    .clk, .rstN, .pushValid, .pushFifoId, .pushData, .popReady, .popValid, .popData,
    .popEmpty, .mismatches, .pops, .queued
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Every cycle with pushCredit high hands the sender one credit
  always @(posedge clk) begin
    if (!rstN) begin
      creditsIn <= 0;
    end else if (pushCredit) begin
      creditsIn <= creditsIn + 1;
    end
  end

  function automatic int heldCredits();
    return creditsIn - pushesSent;
  endfunction

  // All driving happens here, on the falling edge
  task automatic nextCycle();
    logic [31:0] rnd;
    @(negedge clk);
    if (randomReady) begin
      rnd = $random(seed);
      popReady = rnd[3:0];
    end
  endtask

  task automatic expectValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: expected %h, got %h", name, want, got);
      tbErrors++;
    end
  endtask

  task automatic waitHeld(input int target);
    int cycles;
    cycles = 0;
    while (heldCredits() != target && cycles < WaitLimit) begin
      nextCycle();
      cycles++;
    end
    if (heldCredits() != target) begin
      $display("Timeout: sender holds %0d credits, expected %0d", heldCredits(), target);
      tbErrors++;
    end
  endtask

  // Waits until the masked FIFOs are empty in the DUT and in the reference
  task automatic waitEmpty(input logic [3:0] mask, input string what);
    int cycles;
    cycles = 0;
    while (((popEmpty & mask) != mask || (queued & mask) != 0) && cycles < WaitLimit) begin
      nextCycle();
      cycles++;
    end
    if ((popEmpty & mask) != mask || (queued & mask) != 0) begin
      $display("Timeout: gave up waiting for %s", what);
      tbErrors++;
    end
  endtask

  task automatic pushWord(input mfifo_pkg::fifoIdT id, input mfifo_pkg::dataT data);
    int cycles;
    cycles = 0;
    while (heldCredits() == 0 && cycles < WaitLimit) begin
      nextCycle();
      cycles++;
    end
    if (heldCredits() == 0) begin
      $display("Timeout: no credit arrived for a push to FIFO %0d", id);
      tbErrors++;
    end else begin
      pushValid = 1'b1;
      pushFifoId = id;
      pushData = data;
      pushesSent++;
      nextCycle();
      pushValid = 1'b0;
    end
  endtask

  task automatic applyRows(input int testNum);
    for (int i = 0; i < NumRows; i++) begin
      if (int'(StimTable[i].testNum) == testNum) begin
        popReady = StimTable[i].ready;
        pushWord(StimTable[i].fifoId, StimTable[i].data);
      end
    end
  endtask

  task automatic drainAll();
    popReady = '1;
    waitEmpty(4'hF, "all FIFOs to drain");
  endtask

  task automatic finishTest(input int num, input string name);
    int errNow;
    errNow = tbErrors + mismatches;
    if (errNow == errMark) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, errNow - errMark);
      testsFailed++;
    end
    testsRun++;
    errMark = errNow;
  endtask

  initial begin
    logic [31:0] rnd;
    int mark;
    rstN = 1'b0;
    pushValid = 1'b0;
    pushFifoId = '0;
    pushData = '0;
    pushCreditStall = 1'b0;
    creditWithhold = 5'd2;
    popReady = '0;
    randomReady = 1'b0;
    pushesSent = 0;
    tbErrors = 0;
    errMark = 0;
    testsRun = 0;
    testsFailed = 0;

    repeat (3) @(negedge clk);
    expectValue("pushCredit", 32'(pushCredit), 32'd0);
    expectValue("popValid", 32'(popValid), 32'd0);
    expectValue("popEmpty", 32'(popEmpty), 32'hF);
    // Every entry is free after reset
    expectValue("pushFull", 32'(pushFull), 32'd0);
    rstN = 1'b1;
    // Two entries withheld, so credits stop at 14
    waitHeld(14);
    repeat (10) nextCycle();
    expectValue("sender credit total", 32'(heldCredits()), 32'd14);
    finishTest(1, "reset and credits");

    applyRows(2);
    drainAll();
    finishTest(2, "order within a FIFO");

    applyRows(3);
    drainAll();
    finishTest(3, "isolation between FIFOs");

    applyRows(4);
    waitEmpty(4'hB, "FIFOs 0, 1 and 3 to drain");
    expectValue("popValid[2]", 32'(popValid[2]), 32'd1);
    repeat (5) nextCycle();
    drainAll();
    finishTest(4, "back-pressure");

    creditWithhold = 5'd0;
    popReady = '0;
    waitHeld(16);
    // The first word moves into FIFO 3's slot and frees its entry,
    // so the seventeenth push is the one that fills the storage
    for (int i = 0; i < 17; i++) begin
      pushWord(2'd3, mfifo_pkg::dataT'(8'h50 + i));
    end
    nextCycle();
    expectValue("pushFull", 32'(pushFull), 32'd1);
    mark = creditsIn;
    repeat (8) nextCycle();
    expectValue("credits while full", 32'(creditsIn - mark), 32'd0);
    drainAll();
    waitHeld(16);
    finishTest(5, "full and credit return");

    randomReady = 1'b1;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      pushWord(rnd[1:0], rnd[15:8]);
    end
    randomReady = 1'b0;
    drainAll();
    waitHeld(16);
    finishTest(6, "random back-pressure");

    $display("Tests run %0d, failed %0d, words popped %0d, errors %0d",
             testsRun, testsFailed, pops, tbErrors + mismatches);
    if (testsFailed == 0 && tbErrors + mismatches == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
